//--- logic/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// small simulated mode, horizontal geometry in pixels
`define H_ACTIVE 32'd16
`define H_FRONT  32'd2
`define H_SYNC   32'd3
`define H_BACK   32'd3

// vertical geometry in lines
`define V_ACTIVE 32'd8
`define V_FRONT  32'd1
`define V_SYNC   32'd2
`define V_BACK   32'd1

// sync level inside the sync window
// 1 gives active-high pulses
`define HSYNC_POL 1'b1
`define VSYNC_POL 1'b1

// buffer entries between raster and link, power of two
`define FIFO_DEPTH 32'd8

`endif

//--- logic/video_pkg.sv
package video_pkg;

  // active-area view of the payload
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  // blanking view, sync bits on top
  typedef struct packed {
    logic        hsync;
    logic        vsync;
    logic [21:0] rsvd;
  } ctrl_t;

  // same 24 bits, meaning set by the blank flag
  typedef union packed {
    pixel_t pixel;
    ctrl_t  ctrl;
  } payload_t;

  // bit 24 blank, 23..0 payload
  typedef struct packed {
    logic     blank;
    payload_t payload;
  } video_word_t;

  // test pictures
  typedef enum logic [1:0] {
    PAT_SOLID = 2'd0,
    PAT_BARS  = 2'd1,
    PAT_HRAMP = 2'd2,
    PAT_VRAMP = 2'd3
  } pattern_t;

endpackage

//--- logic/tmds_pkg.sv
package tmds_pkg;

  // one 10-bit channel symbol, bit 0 sent first
  typedef logic [9:0] symbol_t;

  // running disparity, ones minus zeros
  typedef logic signed [4:0] disparity_t;

  // control tokens, suffix is {vsync, hsync}
  localparam symbol_t CTRL_00 = 10'b1101010100;
  localparam symbol_t CTRL_01 = 10'b0010101011;
  localparam symbol_t CTRL_10 = 10'b0101010100;
  localparam symbol_t CTRL_11 = 10'b1010101011;

  // token for channel 0 during blanking
  function automatic symbol_t ctrl_token(input logic vsync, input logic hsync);
    symbol_t tok;
    case ({vsync, hsync})
      2'b00:   tok = CTRL_00;
      2'b01:   tok = CTRL_01;
      2'b10:   tok = CTRL_10;
      default: tok = CTRL_11;
    endcase
    return tok;
  endfunction

endpackage

//--- logic/video_timing_gen.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_timing_gen
(
  input  logic                   clk_25mhz,
  input  logic                   arst_n,
  input  video_pkg::pattern_t    pattern,
  input  logic [23:0]            solid_rgb,
  output video_pkg::video_word_t gen_word,
  output logic                   gen_valid,
  input  logic                   gen_ready
);

  localparam int H_TOTAL  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int XW       = $clog2(H_TOTAL);
  localparam int YW       = $clog2(V_TOTAL);
  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END   = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END   = VS_START + `V_SYNC;

  // position of the next word to build
  logic [XW-1:0]          x_cnt;
  logic [YW-1:0]          y_cnt;
  logic                   load;
  logic [2:0]             bar;
  logic                   in_hs;
  logic                   in_vs;
  video_pkg::video_word_t next_word;

  // output slot free or being taken
  assign load = !gen_valid || gen_ready;

  // eight equal bars over the active width
  assign bar = 3'((32'(x_cnt) * 32'd8) / `H_ACTIVE);

  assign in_hs = (32'(x_cnt) >= HS_START) && (32'(x_cnt) < HS_END);
  assign in_vs = (32'(y_cnt) >= VS_START) && (32'(y_cnt) < VS_END);

  always_comb
  begin
    next_word = '0;
    if ((32'(x_cnt) < `H_ACTIVE) && (32'(y_cnt) < `V_ACTIVE))
    begin
      next_word.blank = 1'b0;
      case (pattern)
        video_pkg::PAT_SOLID:
        begin
          next_word.payload.pixel.red   = solid_rgb[23:16];
          next_word.payload.pixel.green = solid_rgb[15:8];
          next_word.payload.pixel.blue  = solid_rgb[7:0];
        end
        video_pkg::PAT_BARS:
        begin
          // bar bit 2 red, bit 1 green, bit 0 blue
          next_word.payload.pixel.red   = {8{bar[2]}};
          next_word.payload.pixel.green = {8{bar[1]}};
          next_word.payload.pixel.blue  = {8{bar[0]}};
        end
        video_pkg::PAT_HRAMP:
        begin
          next_word.payload.pixel.red   = 8'(32'(x_cnt) * 16);
          next_word.payload.pixel.green = 8'(32'(x_cnt) * 16);
          next_word.payload.pixel.blue  = 8'(32'(x_cnt) * 16);
        end
        default:
        begin
          next_word.payload.pixel.red   = 8'(32'(y_cnt) * 32);
          next_word.payload.pixel.green = 8'(32'(y_cnt) * 32);
          next_word.payload.pixel.blue  = 8'(32'(y_cnt) * 32);
        end
      endcase
    end
    else
    begin
      // porches and sync, reserved bits stay zero
      next_word.blank              = 1'b1;
      next_word.payload.ctrl.hsync = in_hs ? `HSYNC_POL : ~`HSYNC_POL;
      next_word.payload.ctrl.vsync = in_vs ? `VSYNC_POL : ~`VSYNC_POL;
    end
  end

  // raster walks only when a word leaves
  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      gen_valid <= 1'b0;
      x_cnt     <= '0;
      y_cnt     <= '0;
    end
    else if (load)
    begin
      gen_valid <= 1'b1;
      if (32'(x_cnt) == H_TOTAL - 1)
      begin
        x_cnt <= '0;
        // end of frame wraps to top line
        y_cnt <= (32'(y_cnt) == V_TOTAL - 1) ? '0 : y_cnt + 1'b1;
      end
      else
      begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // word register, held while stalled
  always_ff @(posedge clk_25mhz)
  begin
    if (load)
      gen_word <= next_word;
  end

endmodule

//--- logic/video_fifo.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_fifo
#(
  parameter int DEPTH = `FIFO_DEPTH
)
(
  input  logic                   clk_25mhz,
  input  logic                   arst_n,
  input  video_pkg::video_word_t wr_word,
  input  logic                   wr_valid,
  output logic                   wr_ready,
  output video_pkg::video_word_t rd_word,
  output logic                   rd_valid,
  input  logic                   rd_ready
);

  localparam int AW = $clog2(DEPTH);

  // storage, no reset needed
  video_pkg::video_word_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign wr_ready = (count != (AW+1)'(DEPTH));
  assign rd_valid = (count != '0);

  assign do_wr = wr_valid && wr_ready;
  assign do_rd = rd_valid && rd_ready;

  // head word shows without a read request
  assign rd_word = mem[rd_ptr];

  always_ff @(posedge clk_25mhz)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_word;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      // read and write together keep the count
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/tmds_encoder.sv
`timescale 1ns/1ns

module tmds_encoder
(
  input  logic                   clk_25mhz,
  input  logic                   arst_n,
  input  video_pkg::video_word_t in_word,
  input  logic                   in_valid,
  output logic                   in_ready,
  output tmds_pkg::symbol_t      tmds_ch0,
  output tmds_pkg::symbol_t      tmds_ch1,
  output tmds_pkg::symbol_t      tmds_ch2,
  output logic                   tmds_valid,
  input  logic                   tmds_ready
);

  // transition minimizing, bit 8 high when xor was used
  function automatic logic [8:0] tm_encode(input logic [7:0] d);
    logic [8:0] q;
    logic       use_xnor;
    use_xnor = ($countones(d) > 4) || (($countones(d) == 4) && !d[0]);
    q[0] = d[0];
    for (int i = 1; i < 8; i++)
      q[i] = use_xnor ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
    q[8] = ~use_xnor;
    return q;
  endfunction

  // dc balance step of the DVI encode rule
  function automatic void dc_balance(input logic [8:0] qm, input tmds_pkg::disparity_t cnt,
                                     output tmds_pkg::symbol_t sym,
                                     output tmds_pkg::disparity_t cnt_nxt);
    int diff;
    int c;
    // ones minus zeros of the low byte
    diff = 2 * $countones(qm[7:0]) - 8;
    c    = int'(cnt);
    if ((c == 0) || (diff == 0))
    begin
      sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
      c   = qm[8] ? c + diff : c - diff;
    end
    else if (((c > 0) && (diff > 0)) || ((c < 0) && (diff < 0)))
    begin
      // invert to pull back toward zero
      sym = {1'b1, qm[8], ~qm[7:0]};
      c   = c + (qm[8] ? 2 : 0) - diff;
    end
    else
    begin
      sym = {1'b0, qm[8], qm[7:0]};
      c   = c - (qm[8] ? 0 : 2) + diff;
    end
    cnt_nxt = tmds_pkg::disparity_t'(c);
  endfunction

  // both stages move together
  logic adv;

  logic       s1_valid;
  logic [8:0] s1_qm [3];
  logic       s1_blank;
  logic       s1_hsync;
  logic       s1_vsync;

  logic                 s2_valid;
  tmds_pkg::symbol_t    sym_q    [3];
  tmds_pkg::disparity_t disp     [3];
  tmds_pkg::symbol_t    sym_nxt  [3];
  tmds_pkg::disparity_t disp_nxt [3];

  // move on when stage 2 is empty or drained this cycle
  assign adv      = !s2_valid || tmds_ready;
  assign in_ready = adv;

  // stage 1, ch0 blue, ch1 green, ch2 red
  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
      s1_valid <= 1'b0;
    else if (adv)
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk_25mhz)
  begin
    if (adv)
    begin
      s1_qm[0] <= tm_encode(in_word.payload.pixel.blue);
      s1_qm[1] <= tm_encode(in_word.payload.pixel.green);
      s1_qm[2] <= tm_encode(in_word.payload.pixel.red);
      s1_blank <= in_word.blank;
      s1_hsync <= in_word.payload.ctrl.hsync;
      s1_vsync <= in_word.payload.ctrl.vsync;
    end
  end

  always_comb
  begin
    for (int ch = 0; ch < 3; ch++)
      dc_balance(s1_qm[ch], disp[ch], sym_nxt[ch], disp_nxt[ch]);
  end

  // stage 2, control token and zero disparity while blank
  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s2_valid <= 1'b0;
      for (int ch = 0; ch < 3; ch++)
      begin
        sym_q[ch] <= tmds_pkg::CTRL_00;
        disp[ch]  <= '0;
      end
    end
    else if (adv)
    begin
      s2_valid <= s1_valid;
      if (s1_valid)
      begin
        for (int ch = 0; ch < 3; ch++)
        begin
          if (s1_blank)
          begin
            sym_q[ch] <= (ch == 0) ? tmds_pkg::ctrl_token(s1_vsync, s1_hsync)
                                   : tmds_pkg::CTRL_00;
            disp[ch]  <= '0;
          end
          else
          begin
            sym_q[ch] <= sym_nxt[ch];
            disp[ch]  <= disp_nxt[ch];
          end
        end
      end
    end
  end

  assign tmds_ch0   = sym_q[0];
  assign tmds_ch1   = sym_q[1];
  assign tmds_ch2   = sym_q[2];
  assign tmds_valid = s2_valid;

endmodule

//--- logic/dvi_tx_top.sv
`timescale 1ns/1ns

module dvi_tx_top
(
  input  logic                clk_25mhz,
  input  logic                arst_n,
  input  video_pkg::pattern_t pattern,
  input  logic [23:0]         solid_rgb,
  input  logic                tmds_ready,
  output tmds_pkg::symbol_t   tmds_ch0,
  output tmds_pkg::symbol_t   tmds_ch1,
  output tmds_pkg::symbol_t   tmds_ch2,
  output logic                tmds_valid
);

  // raster to buffer
  video_pkg::video_word_t gen_word;
  logic                   gen_valid;
  logic                   gen_ready;

  // buffer to encoder
  video_pkg::video_word_t buf_word;
  logic                   buf_valid;
  logic                   buf_ready;

  video_timing_gen u_gen
  (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .pattern   (pattern),
    .solid_rgb (solid_rgb),
    .gen_word  (gen_word),
    .gen_valid (gen_valid),
    .gen_ready (gen_ready)
  );

  // default depth from the consts header
  video_fifo u_fifo
  (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .wr_word   (gen_word),
    .wr_valid  (gen_valid),
    .wr_ready  (gen_ready),
    .rd_word   (buf_word),
    .rd_valid  (buf_valid),
    .rd_ready  (buf_ready)
  );

  // tmds_ready stands in for the serializer
  tmds_encoder u_enc
  (
    .clk_25mhz  (clk_25mhz),
    .arst_n     (arst_n),
    .in_word    (buf_word),
    .in_valid   (buf_valid),
    .in_ready   (buf_ready),
    .tmds_ch0   (tmds_ch0),
    .tmds_ch1   (tmds_ch1),
    .tmds_ch2   (tmds_ch2),
    .tmds_valid (tmds_valid),
    .tmds_ready (tmds_ready)
  );

endmodule

//--- tb/dvi_tx_props.sv
`timescale 1ns/1ns

module dvi_tx_props
#(
  parameter int CAP = 1
)
(
  input logic                 clk_25mhz,
  input logic                 arst_n,
  input logic                 up_valid,
  input logic                 up_ready,
  input logic [24:0]          up_data,
  input logic                 dn_valid,
  input logic                 dn_ready,
  input logic [29:0]          dn_data,
  input tmds_pkg::disparity_t disp0,
  input tmds_pkg::disparity_t disp1,
  input tmds_pkg::disparity_t disp2
);

  // words taken in and not yet handed on
  int occ;

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
      occ <= 0;
    else
      occ <= occ + int'(up_valid && up_ready) - int'(dn_valid && dn_ready);
  end

  // sender holds valid and data while stalled
  up_hold: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    up_valid && !up_ready |=> up_valid && $stable(up_data))
    else $error("input stream changed while stalled");

  dn_hold: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    dn_valid && !dn_ready |=> dn_valid && $stable(dn_data))
    else $error("output stream changed while stalled");

  // no write into a full buffer that is not draining
  no_overflow: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    (occ == CAP) && !(dn_valid && dn_ready) |-> !(up_valid && up_ready))
    else $error("write accepted while full");

  disp_bound: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    (disp0 >= -10) && (disp0 <= 10) && (disp1 >= -10) && (disp1 <= 10) &&
    (disp2 >= -10) && (disp2 <= 10))
    else $error("running disparity out of range");

endmodule

bind video_fifo dvi_tx_props #(.CAP(DEPTH)) u_fifo_props
(
  .clk_25mhz (clk_25mhz),
  .arst_n    (arst_n),
  .up_valid  (wr_valid),
  .up_ready  (wr_ready),
  .up_data   (wr_word),
  .dn_valid  (rd_valid),
  .dn_ready  (rd_ready),
  .dn_data   ({5'b0, rd_word}),
  .disp0     (5'sd0),
  .disp1     (5'sd0),
  .disp2     (5'sd0)
);

// two register stages in flight
bind tmds_encoder dvi_tx_props #(.CAP(2)) u_enc_props
(
  .clk_25mhz (clk_25mhz),
  .arst_n    (arst_n),
  .up_valid  (in_valid),
  .up_ready  (in_ready),
  .up_data   (in_word),
  .dn_valid  (tmds_valid),
  .dn_ready  (tmds_ready),
  .dn_data   ({tmds_ch2, tmds_ch1, tmds_ch0}),
  .disp0     (disp[0]),
  .disp1     (disp[1]),
  .disp2     (disp[2])
);

//--- tb/dvi_tx_tb.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module dvi_tx_tb;

  localparam int H_TOTAL    = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL    = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int FRAME      = H_TOTAL * V_TOTAL;
  localparam int NROWS      = 4;
  localparam int RST_CYCLES = 8;
  localparam int DISP_MAX   = 10;
  // rows x frame symbols x four cycles x 40 ns, plus reset and pipeline fill
  localparam longint WATCHDOG_NS = longint'(NROWS * FRAME * 4 + RST_CYCLES + 16) * 40;

  logic                clk_25mhz;
  logic                arst_n;
  video_pkg::pattern_t pattern;
  logic [23:0]         solid_rgb;
  logic                tmds_ready;
  tmds_pkg::symbol_t   tmds_ch0;
  tmds_pkg::symbol_t   tmds_ch1;
  tmds_pkg::symbol_t   tmds_ch2;
  logic                tmds_valid;

  // stimulus table, one frame per row
  video_pkg::pattern_t row_pat   [NROWS];
  logic [23:0]         row_solid [NROWS];
  logic [23:0]         row_probe [NROWS][3];
  tmds_pkg::symbol_t   row_ctrl  [NROWS];
  int                  probe_x   [3];
  int                  probe_y   [3];

  // model raster and bookkeeping
  tmds_pkg::symbol_t s0;
  tmds_pkg::symbol_t s1;
  tmds_pkg::symbol_t s2;
  int mx;
  int my;
  int run_len;
  int runs;
  int active_cnt;
  int sum [3];
  int errors;
  int checks;
  int tests;
  int failed_tests;

  dvi_tx_top uut
  (
    .clk_25mhz  (clk_25mhz),
    .arst_n     (arst_n),
    .pattern    (pattern),
    .solid_rgb  (solid_rgb),
    .tmds_ready (tmds_ready),
    .tmds_ch0   (tmds_ch0),
    .tmds_ch1   (tmds_ch1),
    .tmds_ch2   (tmds_ch2),
    .tmds_valid (tmds_valid)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  // serializer stand-in, ready about 3 of 4 cycles
  always @(posedge clk_25mhz)
  begin
    #2;
    tmds_ready = ($urandom % 4) != 0;
  end

  // hang guard
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all frames were checked");
    $display("Checks failed");
    $finish;
  end

  task automatic load_table();
    probe_x = '{0, 7, 15};
    probe_y = '{0, 3, 7};
    // pattern, solid colour, probes at (0,0) (7,3) (15,7), token at hsync start
    row_pat[0] = video_pkg::PAT_SOLID;
    row_solid[0] = 24'h3CA50F;
    row_probe[0] = '{24'h3CA50F, 24'h3CA50F, 24'h3CA50F};
    row_ctrl[0] = tmds_pkg::CTRL_01;
    row_pat[1] = video_pkg::PAT_BARS;
    row_solid[1] = 24'h000000;
    row_probe[1] = '{24'h000000, 24'h00FFFF, 24'hFFFFFF};
    row_ctrl[1] = tmds_pkg::CTRL_01;
    row_pat[2] = video_pkg::PAT_HRAMP;
    row_solid[2] = 24'h123456;
    row_probe[2] = '{24'h000000, 24'h707070, 24'hF0F0F0};
    row_ctrl[2] = tmds_pkg::CTRL_01;
    row_pat[3] = video_pkg::PAT_VRAMP;
    row_solid[3] = 24'hFFFFFF;
    row_probe[3] = '{24'h000000, 24'h606060, 24'hE0E0E0};
    row_ctrl[3] = tmds_pkg::CTRL_01;
  endtask

  // picture rule per pixel
  function automatic logic [23:0] pixel_rule(input video_pkg::pattern_t p,
                                             input logic [23:0] solid, input int x, input int y);
    logic [7:0] v;
    int         bar;
    bar = (x * 8) / `H_ACTIVE;
    case (p)
      video_pkg::PAT_SOLID: return solid;
      video_pkg::PAT_BARS:  return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
      video_pkg::PAT_HRAMP: v = 8'(x * 16);
      default:              v = 8'(y * 32);
    endcase
    return {v, v, v};
  endfunction

  // DVI decode, undo inversion then xor or xnor chain
  function automatic logic [7:0] decode_symbol(input tmds_pkg::symbol_t s);
    logic [7:0] d;
    logic [7:0] q;
    d = s[9] ? ~s[7:0] : s[7:0];
    q[0] = d[0];
    for (int i = 1; i < 8; i++)
      q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    return q;
  endfunction

  function automatic int ones_minus_zeros(input tmds_pkg::symbol_t s);
    return 2 * $countones(s) - 10;
  endfunction

  // channel 0 token, index is {vsync, hsync}
  function automatic tmds_pkg::symbol_t expected_token(input logic vs, input logic hs);
    case ({vs, hs})
      2'b00:   return tmds_pkg::CTRL_00;
      2'b01:   return tmds_pkg::CTRL_01;
      2'b10:   return tmds_pkg::CTRL_10;
      default: return tmds_pkg::CTRL_11;
    endcase
  endfunction

  // any of the four blanking tokens
  function automatic logic is_token(input tmds_pkg::symbol_t s);
    return (s == tmds_pkg::CTRL_00) || (s == tmds_pkg::CTRL_01) ||
           (s == tmds_pkg::CTRL_10) || (s == tmds_pkg::CTRL_11);
  endfunction

  task automatic check_symbol(input string name, input tmds_pkg::symbol_t got,
                              input tmds_pkg::symbol_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_pixel(input string name, input video_pkg::video_word_t got,
                             input video_pkg::video_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_balance(input string name, input int got);
    checks++;
    if ((got > DISP_MAX) || (got < -DISP_MAX))
    begin
      errors++;
      $display("[FAIL] t=%0t %s got %0d expected within +/-%0d", $time, name, got, DISP_MAX);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors != err0)
      failed_tests++;
    $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  // wait for the next accepted symbol
  task automatic next_symbol();
    do
      @(posedge clk_25mhz);
    while (!(tmds_valid && tmds_ready));
    s0 = tmds_ch0;
    s1 = tmds_ch1;
    s2 = tmds_ch2;
  endtask

  task automatic process_symbol(input int r);
    video_pkg::video_word_t got_w;
    video_pkg::video_word_t exp_w;
    tmds_pkg::symbol_t      syms [3];
    logic                   hs;
    logic                   vs;
    logic                   link_active;
    syms = '{s0, s1, s2};
    // runs as seen on the link, ended by the first token
    link_active = !(is_token(s0) && (s1 == tmds_pkg::CTRL_00) &&
                    (s2 == tmds_pkg::CTRL_00));
    if (link_active)
    begin
      run_len++;
      active_cnt++;
    end
    else if (run_len != 0)
    begin
      check_count("run length", run_len, `H_ACTIVE);
      runs++;
      run_len = 0;
    end
    if ((mx < `H_ACTIVE) && (my < `V_ACTIVE))
    begin
      got_w = '0;
      exp_w = '0;
      // ch0 blue, ch1 green, ch2 red
      got_w.payload.pixel.red   = decode_symbol(s2);
      got_w.payload.pixel.green = decode_symbol(s1);
      got_w.payload.pixel.blue  = decode_symbol(s0);
      exp_w.payload = pixel_rule(row_pat[r], row_solid[r], mx, my);
      check_pixel($sformatf("pixel x%0d y%0d", mx, my), got_w, exp_w);
      for (int p = 0; p < 3; p++)
      begin
        if ((mx == probe_x[p]) && (my == probe_y[p]))
        begin
          exp_w.payload = row_probe[r][p];
          check_pixel($sformatf("probe %0d", p), got_w, exp_w);
        end
      end
      // disparity restarts with each run
      if (mx == 0)
        sum = '{0, 0, 0};
      for (int ch = 0; ch < 3; ch++)
      begin
        sum[ch] += ones_minus_zeros(syms[ch]);
        check_balance($sformatf("balance ch%0d", ch), sum[ch]);
      end
    end
    else
    begin
      hs = (mx >= `H_ACTIVE + `H_FRONT) && (mx < `H_ACTIVE + `H_FRONT + `H_SYNC);
      vs = (my >= `V_ACTIVE + `V_FRONT) && (my < `V_ACTIVE + `V_FRONT + `V_SYNC);
      check_symbol("tmds_ch0", s0, expected_token(vs, hs));
      check_symbol("tmds_ch1", s1, tmds_pkg::CTRL_00);
      check_symbol("tmds_ch2", s2, tmds_pkg::CTRL_00);
      if ((mx == `H_ACTIVE + `H_FRONT) && (my == 0))
        check_symbol("tmds_ch0 probe", s0, row_ctrl[r]);
    end
  endtask

  initial
  begin
    int err0;
    void'($urandom(52));
    clk_25mhz    = 1'b0;
    arst_n       = 1'b0;
    tmds_ready   = 1'b0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    load_table();
    pattern   = row_pat[0];
    solid_rgb = row_solid[0];

    // outputs idle through reset
    err0 = errors;
    repeat (RST_CYCLES)
    begin
      @(posedge clk_25mhz);
      #2;
      check_count("tmds_valid", int'(tmds_valid), 0);
      check_symbol("tmds_ch0", tmds_ch0, tmds_pkg::CTRL_00);
      check_symbol("tmds_ch1", tmds_ch1, tmds_pkg::CTRL_00);
      check_symbol("tmds_ch2", tmds_ch2, tmds_pkg::CTRL_00);
    end
    arst_n = 1'b1;
    report_test("reset", err0);

    mx = 0;
    my = 0;
    for (int r = 0; r < NROWS; r++)
    begin
      err0       = errors;
      runs       = 0;
      active_cnt = 0;
      run_len    = 0;
      for (int n = 0; n < FRAME; n++)
      begin
        next_symbol();
        process_symbol(r);
        mx++;
        if (mx == H_TOTAL)
        begin
          mx = 0;
          my = (my == V_TOTAL - 1) ? 0 : my + 1;
        end
        // switch picture in vertical blanking, producer runs only a few words ahead
        if ((mx == 0) && (my == `V_ACTIVE) && (r + 1 < NROWS))
        begin
          #2;
          pattern   = row_pat[r+1];
          solid_rgb = row_solid[r+1];
        end
      end
      check_count("active symbols", active_cnt, `H_ACTIVE * `V_ACTIVE);
      check_count("active runs", runs, `V_ACTIVE);
      report_test($sformatf("frame %0d %s", r, row_pat[r].name()), err0);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests,
             checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
logic/video_pkg.sv
logic/tmds_pkg.sv
logic/video_timing_gen.sv
logic/video_fifo.sv
logic/tmds_encoder.sv
logic/dvi_tx_top.sv
tb/dvi_tx_props.sv
tb/dvi_tx_tb.sv

//--- Makefile
# Verilator flow for the DVI transmitter testbench
VERILATOR ?= verilator
TOP       ?= dvi_tx_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(wildcard logic/*.sv logic/*.svh tb/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "All checks passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
